/* hdl/branch_unit.sv */
`timescale 1ns/1ps

module branch_unit (
  input  logic [id_pkg::pc_w-1:0]    pc_i,
  input  id_pkg::inst_t              inst_i,
  input  logic [id_pkg::aluop_w-1:0] aluop_i,
  input  logic [id_pkg::reg_w-1:0]   op1_i,
  input  logic [id_pkg::reg_w-1:0]   op2_i,
  output logic                       branch_flag_o,
  output logic [id_pkg::pc_w-1:0]    branch_target_o,
  output logic [id_pkg::reg_w-1:0]   link_addr_o
);
  import id_pkg::*;

  logic [pc_w-1:0] pc_plus_4;
  logic [pc_w-1:0] pc_plus_8;
  logic [pc_w-1:0] br_target;
  logic [pc_w-1:0] jmp_target;
  logic            taken;

  assign pc_plus_4  = pc_i + 32'd4;
  assign pc_plus_8  = pc_i + 32'd8;
  assign br_target  = pc_plus_4 + {{14{inst_i.i.imm16[15]}}, inst_i.i.imm16, 2'b00};
  assign jmp_target = {pc_plus_4[31:28], inst_i.j.target26, 2'b00};  // same 256MB region

  always_comb begin
    case (aluop_i)
      aluop_beq:  taken = (op1_i == op2_i);
      aluop_bne:  taken = (op1_i != op2_i);
      aluop_bgtz: taken = !op1_i[31] && (op1_i != '0);
      aluop_blez: taken = op1_i[31] || (op1_i == '0);
      aluop_bgez: taken = !op1_i[31];
      aluop_bltz: taken = op1_i[31];
      default:    taken = 1'b0;
    endcase
  end

  always_comb begin
    branch_flag_o   = taken;
    branch_target_o = taken ? br_target : '0;
    link_addr_o     = '0;
    case (aluop_i)
      aluop_j, aluop_jal: begin
        branch_flag_o   = 1'b1;
        branch_target_o = jmp_target;
      end
      aluop_jr, aluop_jalr: begin
        branch_flag_o   = 1'b1;
        branch_target_o = op1_i;
      end
      default: ;
    endcase
    if (aluop_i == aluop_jal || aluop_i == aluop_jalr) link_addr_o = pc_plus_8;
  end

endmodule

/* hdl/id_pkg.sv */
package id_pkg;

  localparam int reg_w    = 32;
  localparam int addr_w   = 5;
  localparam int pc_w     = 32;
  localparam int aluop_w  = 8;
  localparam int alusel_w = 3;

  localparam logic [addr_w-1:0] link_reg = 5'd31;  // jal destination

  // primary opcodes
  localparam logic [5:0] op_special = 6'b000000;
  localparam logic [5:0] op_regimm  = 6'b000001;
  localparam logic [5:0] op_ori     = 6'b001101;
  localparam logic [5:0] op_andi    = 6'b001100;
  localparam logic [5:0] op_xori    = 6'b001110;
  localparam logic [5:0] op_lui     = 6'b001111;
  localparam logic [5:0] op_slti    = 6'b001010;
  localparam logic [5:0] op_sltiu   = 6'b001011;
  localparam logic [5:0] op_addi    = 6'b001000;
  localparam logic [5:0] op_addiu   = 6'b001001;
  localparam logic [5:0] op_j       = 6'b000010;
  localparam logic [5:0] op_jal     = 6'b000011;
  localparam logic [5:0] op_beq     = 6'b000100;
  localparam logic [5:0] op_bne     = 6'b000101;
  localparam logic [5:0] op_bgtz    = 6'b000111;
  localparam logic [5:0] op_blez    = 6'b000110;
  localparam logic [5:0] op_lb      = 6'b100000;
  localparam logic [5:0] op_lw      = 6'b100011;
  localparam logic [5:0] op_sb      = 6'b101000;
  localparam logic [5:0] op_sw      = 6'b101011;

  // SPECIAL function field
  localparam logic [5:0] fn_or   = 6'b100101;
  localparam logic [5:0] fn_and  = 6'b100100;
  localparam logic [5:0] fn_xor  = 6'b100110;
  localparam logic [5:0] fn_nor  = 6'b100111;
  localparam logic [5:0] fn_sll  = 6'b000000;
  localparam logic [5:0] fn_srl  = 6'b000010;
  localparam logic [5:0] fn_sra  = 6'b000011;
  localparam logic [5:0] fn_sllv = 6'b000100;
  localparam logic [5:0] fn_srlv = 6'b000110;
  localparam logic [5:0] fn_srav = 6'b000111;
  localparam logic [5:0] fn_slt  = 6'b101010;
  localparam logic [5:0] fn_sltu = 6'b101011;
  localparam logic [5:0] fn_add  = 6'b100000;
  localparam logic [5:0] fn_addu = 6'b100001;
  localparam logic [5:0] fn_sub  = 6'b100010;
  localparam logic [5:0] fn_subu = 6'b100011;
  localparam logic [5:0] fn_jr   = 6'b001000;
  localparam logic [5:0] fn_jalr = 6'b001001;

  localparam logic [4:0] rt_bgez = 5'b00001;  // REGIMM rt field
  localparam logic [4:0] rt_bltz = 5'b00000;

  localparam logic [aluop_w-1:0] aluop_nop   = 8'b00000000;
  localparam logic [aluop_w-1:0] aluop_or    = 8'b00100101;
  localparam logic [aluop_w-1:0] aluop_and   = 8'b00100100;
  localparam logic [aluop_w-1:0] aluop_xor   = 8'b00100110;
  localparam logic [aluop_w-1:0] aluop_nor   = 8'b00100111;
  localparam logic [aluop_w-1:0] aluop_sll   = 8'b01111100;
  localparam logic [aluop_w-1:0] aluop_srl   = 8'b00000010;
  localparam logic [aluop_w-1:0] aluop_sra   = 8'b00000011;
  localparam logic [aluop_w-1:0] aluop_slt   = 8'b00101010;
  localparam logic [aluop_w-1:0] aluop_sltu  = 8'b00101011;
  localparam logic [aluop_w-1:0] aluop_add   = 8'b00100000;
  localparam logic [aluop_w-1:0] aluop_addu  = 8'b00100001;
  localparam logic [aluop_w-1:0] aluop_sub   = 8'b00100010;
  localparam logic [aluop_w-1:0] aluop_subu  = 8'b00100011;
  localparam logic [aluop_w-1:0] aluop_addi  = 8'b01010101;
  localparam logic [aluop_w-1:0] aluop_addiu = 8'b01010110;
  localparam logic [aluop_w-1:0] aluop_j     = 8'b01001111;
  localparam logic [aluop_w-1:0] aluop_jal   = 8'b01010000;
  localparam logic [aluop_w-1:0] aluop_jr    = 8'b00001000;
  localparam logic [aluop_w-1:0] aluop_jalr  = 8'b00001001;
  localparam logic [aluop_w-1:0] aluop_beq   = 8'b01010001;
  localparam logic [aluop_w-1:0] aluop_bne   = 8'b01010010;
  localparam logic [aluop_w-1:0] aluop_bgtz  = 8'b01010100;
  localparam logic [aluop_w-1:0] aluop_blez  = 8'b01010011;
  localparam logic [aluop_w-1:0] aluop_bgez  = 8'b01000001;
  localparam logic [aluop_w-1:0] aluop_bltz  = 8'b01000000;
  localparam logic [aluop_w-1:0] aluop_lb    = 8'b11100000;
  localparam logic [aluop_w-1:0] aluop_lw    = 8'b11100011;
  localparam logic [aluop_w-1:0] aluop_sb    = 8'b11101000;
  localparam logic [aluop_w-1:0] aluop_sw    = 8'b11101011;

  localparam logic [alusel_w-1:0] sel_nop   = 3'b000;
  localparam logic [alusel_w-1:0] sel_logic = 3'b001;
  localparam logic [alusel_w-1:0] sel_shift = 3'b010;
  localparam logic [alusel_w-1:0] sel_arith = 3'b100;
  localparam logic [alusel_w-1:0] sel_jump  = 3'b110;
  localparam logic [alusel_w-1:0] sel_ldst  = 3'b111;

  typedef struct packed {
    logic [5:0] op;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    logic [5:0] funct;
  } r_fields_t;

  typedef struct packed {
    logic [5:0]  op;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] imm16;
  } i_fields_t;

  typedef struct packed {
    logic [5:0]  op;
    logic [25:0] target26;
  } j_fields_t;

  typedef union packed {
    r_fields_t r;
    i_fields_t i;
    j_fields_t j;
  } inst_t;

endpackage

/* hdl/id_stage.sv */
`timescale 1ns/1ps

module id_stage #(
  parameter int nregs = 32
) (
  input  logic                        clk,
  input  logic                        rst_i,
  input  logic [id_pkg::pc_w-1:0]     pc_i,
  input  id_pkg::inst_t               inst_i,
  input  logic                        ex_we_i,
  input  logic [id_pkg::addr_w-1:0]   ex_waddr_i,
  input  logic [id_pkg::reg_w-1:0]    ex_wdata_i,
  input  logic [id_pkg::aluop_w-1:0]  ex_aluop_i,
  input  logic                        mem_we_i,
  input  logic [id_pkg::addr_w-1:0]   mem_waddr_i,
  input  logic [id_pkg::reg_w-1:0]    mem_wdata_i,
  input  logic                        wb_we_i,
  input  logic [id_pkg::addr_w-1:0]   wb_waddr_i,
  input  logic [id_pkg::reg_w-1:0]    wb_wdata_i,
  output logic [id_pkg::aluop_w-1:0]  aluop_o,
  output logic [id_pkg::alusel_w-1:0] alusel_o,
  output logic [id_pkg::reg_w-1:0]    reg1_data_o,
  output logic [id_pkg::reg_w-1:0]    reg2_data_o,
  output logic [id_pkg::addr_w-1:0]   waddr_o,
  output logic                        we_o,
  output logic                        inst_valid_o,
  output logic                        branch_flag_o,
  output logic [id_pkg::pc_w-1:0]     branch_target_o,
  output logic [id_pkg::reg_w-1:0]    link_addr_o,
  output logic                        stallreq_o
);
  import id_pkg::*;

  logic             re1, re2;
  logic [addr_w-1:0] raddr1, raddr2;
  logic [reg_w-1:0] imm;
  logic [reg_w-1:0] rf_data1, rf_data2;
  logic             stall1, stall2;

  inst_decoder u_dec (
    .rst_i, .inst_i, .aluop_o, .alusel_o,
    .re1_o(re1), .re2_o(re2), .raddr1_o(raddr1), .raddr2_o(raddr2),
    .waddr_o, .we_o, .imm_o(imm), .inst_valid_o
  );

  regfile #(.nregs(nregs)) u_rf (
    .clk, .rst_i, .we_i(wb_we_i), .waddr_i(wb_waddr_i), .wdata_i(wb_wdata_i),
    .re1_i(re1), .raddr1_i(raddr1), .rdata1_o(rf_data1),
    .re2_i(re2), .raddr2_i(raddr2), .rdata2_o(rf_data2)
  );

  operand_mux #(.nregs(nregs)) u_op1 (
    .re_i(re1), .raddr_i(raddr1), .rf_data_i(rf_data1), .imm_i(imm),
    .ex_we_i, .ex_waddr_i, .ex_wdata_i, .ex_aluop_i,
    .mem_we_i, .mem_waddr_i, .mem_wdata_i,
    .operand_o(reg1_data_o), .stall_o(stall1)
  );

  operand_mux #(.nregs(nregs)) u_op2 (
    .re_i(re2), .raddr_i(raddr2), .rf_data_i(rf_data2), .imm_i(imm),
    .ex_we_i, .ex_waddr_i, .ex_wdata_i, .ex_aluop_i,
    .mem_we_i, .mem_waddr_i, .mem_wdata_i,
    .operand_o(reg2_data_o), .stall_o(stall2)
  );

  branch_unit u_br (
    .pc_i, .inst_i, .aluop_i(aluop_o), .op1_i(reg1_data_o), .op2_i(reg2_data_o),
    .branch_flag_o, .branch_target_o, .link_addr_o
  );

  assign stallreq_o = stall1 | stall2;  // either operand waits on a load

endmodule

/* hdl/inst_decoder.sv */
`timescale 1ns/1ps

module inst_decoder (
  input  logic                        rst_i,
  input  id_pkg::inst_t               inst_i,
  output logic [id_pkg::aluop_w-1:0]  aluop_o,
  output logic [id_pkg::alusel_w-1:0] alusel_o,
  output logic                        re1_o,
  output logic                        re2_o,
  output logic [id_pkg::addr_w-1:0]   raddr1_o,
  output logic [id_pkg::addr_w-1:0]   raddr2_o,
  output logic [id_pkg::addr_w-1:0]   waddr_o,
  output logic                        we_o,
  output logic [id_pkg::reg_w-1:0]    imm_o,
  output logic                        inst_valid_o
);
  import id_pkg::*;

  logic [reg_w-1:0] imm_zext;
  logic [reg_w-1:0] imm_sext;

  assign imm_zext = {16'h0, inst_i.i.imm16};
  assign imm_sext = {{16{inst_i.i.imm16[15]}}, inst_i.i.imm16};

  always_comb begin
    aluop_o      = aluop_nop;
    alusel_o     = sel_nop;
    re1_o        = 1'b0;
    re2_o        = 1'b0;
    raddr1_o     = inst_i.r.rs;
    raddr2_o     = inst_i.r.rt;
    waddr_o      = inst_i.r.rd;  // R-type default
    we_o         = 1'b0;
    imm_o        = '0;
    inst_valid_o = 1'b0;
    if (rst_i) begin
      raddr1_o     = '0;
      raddr2_o     = '0;
      waddr_o      = '0;
      inst_valid_o = 1'b1;  // bubble
    end else begin
      case (inst_i.r.op)
        op_special: begin
          {we_o, re1_o, re2_o, inst_valid_o} = 4'b1111;
          case (inst_i.r.funct)
            fn_or:   {aluop_o, alusel_o} = {aluop_or, sel_logic};
            fn_and:  {aluop_o, alusel_o} = {aluop_and, sel_logic};
            fn_xor:  {aluop_o, alusel_o} = {aluop_xor, sel_logic};
            fn_nor:  {aluop_o, alusel_o} = {aluop_nor, sel_logic};
            fn_sllv: {aluop_o, alusel_o} = {aluop_sll, sel_shift};
            fn_srlv: {aluop_o, alusel_o} = {aluop_srl, sel_shift};
            fn_srav: {aluop_o, alusel_o} = {aluop_sra, sel_shift};
            fn_slt:  {aluop_o, alusel_o} = {aluop_slt, sel_arith};
            fn_sltu: {aluop_o, alusel_o} = {aluop_sltu, sel_arith};
            fn_add:  {aluop_o, alusel_o} = {aluop_add, sel_arith};
            fn_addu: {aluop_o, alusel_o} = {aluop_addu, sel_arith};
            fn_sub:  {aluop_o, alusel_o} = {aluop_sub, sel_arith};
            fn_subu: {aluop_o, alusel_o} = {aluop_subu, sel_arith};
            fn_sll, fn_srl, fn_sra: begin
              re1_o    = 1'b0;  // shamt comes in as operand 1
              imm_o    = {27'h0, inst_i.r.shamt};
              alusel_o = sel_shift;
              aluop_o  = (inst_i.r.funct == fn_sll) ? aluop_sll :
                         (inst_i.r.funct == fn_srl) ? aluop_srl : aluop_sra;
            end
            fn_jr, fn_jalr: begin
              re2_o    = 1'b0;
              we_o     = (inst_i.r.funct == fn_jalr);
              alusel_o = sel_jump;
              aluop_o  = (inst_i.r.funct == fn_jalr) ? aluop_jalr : aluop_jr;
            end
            default: {we_o, re1_o, re2_o, inst_valid_o} = 4'b0000;
          endcase
        end
        op_ori, op_andi, op_xori, op_lui: begin
          {we_o, re1_o, inst_valid_o} = 3'b111;
          waddr_o  = inst_i.i.rt;
          alusel_o = sel_logic;
          imm_o    = imm_zext;
          case (inst_i.i.op)
            op_andi: aluop_o = aluop_and;
            op_xori: aluop_o = aluop_xor;
            op_lui: begin
              aluop_o = aluop_or;  // rs | (imm << 16)
              imm_o   = {inst_i.i.imm16, 16'h0};
            end
            default: aluop_o = aluop_or;
          endcase
        end
        op_slti, op_sltiu, op_addi, op_addiu: begin
          {we_o, re1_o, inst_valid_o} = 3'b111;
          waddr_o  = inst_i.i.rt;
          alusel_o = sel_arith;
          imm_o    = imm_sext;
          case (inst_i.i.op)
            op_slti:  aluop_o = aluop_slt;
            op_sltiu: aluop_o = aluop_sltu;
            op_addi:  aluop_o = aluop_addi;
            default:  aluop_o = aluop_addiu;
          endcase
        end
        op_lb, op_lw: begin
          {we_o, re1_o, inst_valid_o} = 3'b111;
          waddr_o  = inst_i.i.rt;
          alusel_o = sel_ldst;
          aluop_o  = (inst_i.i.op == op_lb) ? aluop_lb : aluop_lw;
        end
        op_sb, op_sw: begin
          {re1_o, re2_o, inst_valid_o} = 3'b111;
          alusel_o = sel_ldst;
          aluop_o  = (inst_i.i.op == op_sb) ? aluop_sb : aluop_sw;
        end
        op_j, op_jal: begin
          inst_valid_o = 1'b1;
          we_o         = (inst_i.j.op == op_jal);
          waddr_o      = link_reg;
          alusel_o     = sel_jump;
          aluop_o      = (inst_i.j.op == op_jal) ? aluop_jal : aluop_j;
        end
        op_beq, op_bne: begin
          {re1_o, re2_o, inst_valid_o} = 3'b111;
          alusel_o = sel_jump;
          aluop_o  = (inst_i.i.op == op_beq) ? aluop_beq : aluop_bne;
        end
        op_bgtz, op_blez: begin
          {re1_o, inst_valid_o} = 2'b11;
          alusel_o = sel_jump;
          aluop_o  = (inst_i.i.op == op_bgtz) ? aluop_bgtz : aluop_blez;
        end
        op_regimm: begin
          if (inst_i.i.rt == rt_bgez || inst_i.i.rt == rt_bltz) begin
            {re1_o, inst_valid_o} = 2'b11;
            alusel_o = sel_jump;
            aluop_o  = (inst_i.i.rt == rt_bgez) ? aluop_bgez : aluop_bltz;
          end
        end
        default: inst_valid_o = 1'b0;
      endcase
    end
  end

endmodule

/* hdl/operand_mux.sv */
`timescale 1ns/1ps

module operand_mux #(
  parameter int nregs = 32
) (
  input  logic                       re_i,
  input  logic [id_pkg::addr_w-1:0]  raddr_i,
  input  logic [id_pkg::reg_w-1:0]   rf_data_i,
  input  logic [id_pkg::reg_w-1:0]   imm_i,
  input  logic                       ex_we_i,
  input  logic [id_pkg::addr_w-1:0]  ex_waddr_i,
  input  logic [id_pkg::reg_w-1:0]   ex_wdata_i,
  input  logic [id_pkg::aluop_w-1:0] ex_aluop_i,
  input  logic                       mem_we_i,
  input  logic [id_pkg::addr_w-1:0]  mem_waddr_i,
  input  logic [id_pkg::reg_w-1:0]   mem_wdata_i,
  output logic [id_pkg::reg_w-1:0]   operand_o,
  output logic                       stall_o
);
  import id_pkg::*;

  logic rd_en;
  logic ex_is_load;
  logic ex_hit;
  logic mem_hit;

  assign rd_en      = re_i && (raddr_i < nregs);  // beyond the file acts as no read
  assign ex_is_load = (ex_aluop_i == aluop_lb) || (ex_aluop_i == aluop_lw);
  assign ex_hit     = rd_en && (ex_waddr_i == raddr_i);
  assign mem_hit    = rd_en && mem_we_i && (mem_waddr_i == raddr_i);

  always_comb begin
    stall_o = 1'b0;
    if (ex_hit && ex_is_load) begin
      stall_o   = 1'b1;  // load data not ready yet
      operand_o = '0;
    end else if (ex_hit && ex_we_i) begin
      operand_o = ex_wdata_i;
    end else if (mem_hit) begin
      operand_o = mem_wdata_i;
    end else if (rd_en) begin
      operand_o = rf_data_i;
    end else begin
      operand_o = imm_i;
    end
  end

endmodule

/* hdl/regfile.sv */
`timescale 1ns/1ps

module regfile #(
  parameter int nregs = 32
) (
  input  logic                      clk,
  input  logic                      rst_i,
  input  logic                      we_i,
  input  logic [id_pkg::addr_w-1:0] waddr_i,
  input  logic [id_pkg::reg_w-1:0]  wdata_i,
  input  logic                      re1_i,
  input  logic [id_pkg::addr_w-1:0] raddr1_i,
  output logic [id_pkg::reg_w-1:0]  rdata1_o,
  input  logic                      re2_i,
  input  logic [id_pkg::addr_w-1:0] raddr2_i,
  output logic [id_pkg::reg_w-1:0]  rdata2_o
);
  import id_pkg::*;

  logic [reg_w-1:0] regs [nregs];

  function automatic logic [reg_w-1:0] read_word(input logic re, input logic [addr_w-1:0] addr,
                                                 input logic [reg_w-1:0] stored);
    if (!re || addr == '0 || addr >= nregs) return '0;  // r0 is hardwired
    if (we_i && addr == waddr_i) return wdata_i;  // write-through
    return stored;
  endfunction

  always_ff @(posedge clk) begin
    if (rst_i) begin
      for (int k = 0; k < nregs; k++) regs[k] <= '0;
    end else if (we_i && waddr_i != '0 && waddr_i < nregs) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  always_comb begin
    rdata1_o = read_word(re1_i, raddr1_i, regs[raddr1_i]);
    rdata2_o = read_word(re2_i, raddr2_i, regs[raddr2_i]);
  end

endmodule

/* sim.f */
hdl/id_pkg.sv
hdl/regfile.sv
hdl/inst_decoder.sv
hdl/operand_mux.sv
hdl/branch_unit.sv
hdl/id_stage.sv
tb/tb_clk_gen.sv
tb/id_stage_props.sv
tb/tb_id_stage.sv

/* tb/id_stage_props.sv */
`timescale 1ns/1ps

module id_stage_props (
  input logic                       clk,
  input logic                       rst_i,
  input logic [id_pkg::aluop_w-1:0] ex_aluop_i,
  input logic                       stallreq_o,
  input logic                       we_o,
  input logic                       branch_flag_o,
  input logic [id_pkg::pc_w-1:0]    branch_target_o
);
  import id_pkg::*;

  int fail_count = 0;  // failed assertions so far

  a_stall_needs_load: assert property (@(posedge clk)
    stallreq_o |-> (ex_aluop_i == aluop_lb || ex_aluop_i == aluop_lw))
    else begin
      $error("stall requested without a load in EX");
      fail_count++;
    end

  a_reset_quiet: assert property (@(posedge clk)
    rst_i |-> (!we_o && !branch_flag_o))
    else begin
      $error("write or branch active during reset");
      fail_count++;
    end

  a_target_idle: assert property (@(posedge clk)
    !branch_flag_o |-> (branch_target_o == '0))
    else begin
      $error("branch target nonzero without a branch");
      fail_count++;
    end

endmodule

bind id_stage id_stage_props u_props (
  .clk, .rst_i, .ex_aluop_i, .stallreq_o, .we_o, .branch_flag_o, .branch_target_o
);

/* tb/id_vectors.txt */
// rst pc inst ex_we ex_waddr ex_wdata ex_aluop mem_we mem_waddr mem_wdata wb_we wb_waddr wb_wdata
// then expected: aluop alusel reg1 reg2 waddr we valid bflag btarget link stall
1 400000 00221825 0 0 0 0 0 0 0 1 1 12345678  0 0 0 0 0 0 1 0 0 0 0
0 400000 00221825 0 0 0 0 0 0 0 0 0 0  25 1 0 0 3 1 1 0 0 0 0
0 400000 00221825 0 0 0 0 0 0 0 1 1 f0f0  25 1 f0f0 0 3 1 1 0 0 0 0
0 400000 00222024 0 0 0 0 0 0 0 1 2 12340f0f  24 1 f0f0 12340f0f 4 1 1 0 0 0 0
0 400000 34258001 0 0 0 0 0 0 0 0 0 0  25 1 f0f0 8001 5 1 1 0 0 0 0
0 400000 3c06abcd 0 0 0 0 0 0 0 0 0 0  25 1 0 abcd0000 6 1 1 0 0 0 0
0 400000 2047fffc 0 0 0 0 0 0 0 0 0 0  55 4 12340f0f fffffffc 7 1 1 0 0 0 0
0 400000 00024100 0 0 0 0 0 0 0 0 0 0  7c 2 4 12340f0f 8 1 1 0 0 0 0
0 400000 00221825 1 1 aaaa0001 20 1 1 bbbb0001 0 0 0  25 1 aaaa0001 12340f0f 3 1 1 0 0 0 0
0 400000 00221825 1 5 aaaa0002 20 1 2 bbbb0002 0 0 0  25 1 f0f0 bbbb0002 3 1 1 0 0 0 0
0 400000 00001825 1 5 cccc0003 20 1 6 dddd0003 1 0 ffffffff  25 1 0 0 3 1 1 0 0 0 0
0 400000 00221825 1 2 dddd0004 e3 0 0 0 0 0 0  25 1 f0f0 0 3 1 1 0 0 0 1
0 400000 34258001 1 5 dddd0005 e0 0 0 0 0 0 0  25 1 f0f0 8001 5 1 1 0 0 0 0
0 400000 10210003 0 0 0 0 0 0 0 0 0 0  51 6 f0f0 f0f0 0 0 1 1 400010 0 0
0 400000 1022ffff 0 0 0 0 0 0 0 0 0 0  51 6 f0f0 12340f0f 1f 0 1 0 0 0 0
0 400000 1422fffe 0 0 0 0 0 0 0 0 0 0  52 6 f0f0 12340f0f 1f 0 1 1 3ffffc 0 0
0 400000 14210010 0 0 0 0 0 0 0 0 0 0  52 6 f0f0 f0f0 0 0 1 0 0 0 0
0 400000 1c200004 0 0 0 0 0 0 0 0 0 0  54 6 f0f0 0 0 0 1 1 400014 0 0
0 400000 1c000004 0 0 0 0 0 0 0 0 0 0  54 6 0 0 0 0 1 0 0 0 0
0 400000 18000008 0 0 0 0 0 0 0 0 0 0  53 6 0 0 0 0 1 1 400024 0 0
0 400000 18200008 0 0 0 0 0 0 0 0 0 0  53 6 f0f0 0 0 0 1 0 0 0 0
0 400000 04210002 0 0 0 0 0 0 0 0 0 0  41 6 f0f0 0 0 0 1 1 40000c 0 0
0 400000 04210002 1 1 80000000 20 0 0 0 0 0 0  41 6 80000000 0 0 0 1 0 0 0 0
0 400000 04200002 1 1 80000000 20 0 0 0 0 0 0  40 6 80000000 0 0 0 1 1 40000c 0 0
0 400000 04200002 0 0 0 0 0 0 0 0 0 0  40 6 f0f0 0 0 0 1 0 0 0 0
0 10000000 08000100 0 0 0 0 0 0 0 0 0 0  4f 6 0 0 1f 0 1 1 10000400 0 0
0 10000000 0c000100 0 0 0 0 0 0 0 0 0 0  50 6 0 0 1f 1 1 1 10000400 10000008 0
0 400000 00200008 0 0 0 0 0 0 0 0 0 0  8 6 f0f0 0 0 0 1 1 f0f0 0 0
0 400000 0040f809 0 0 0 0 0 0 0 0 0 0  9 6 12340f0f 0 1f 1 1 1 12340f0f 400008 0
0 400000 fc000000 0 0 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0 0 0 0

/* tb/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int period     = 10,
  parameter int rst_cycles = 3
) (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #(period / 2) clk_o = ~clk_o;
  end

  initial begin
    rst_o = 1'b1;
    repeat (rst_cycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_o = 1'b0;  // release away from the sampling edge
  end

endmodule

/* tb/tb_id_stage.sv */
`timescale 1ns/1ps

module tb_id_stage;
  import id_pkg::*;

  localparam int n_vec = 30;
  localparam int n_fld = 24;  // 13 inputs then 11 expected outputs
  localparam int rst_cycles = 3;
  localparam int max_cycles = n_vec + rst_cycles + 10;

  logic clk, rst_gen, rst_vec;
  logic [31:0] vec_mem [0:n_vec*n_fld-1];
  int cycles;

  logic [pc_w-1:0]     pc;
  logic [31:0]         inst;
  logic                ex_we, mem_we, wb_we;
  logic [addr_w-1:0]   ex_waddr, mem_waddr, wb_waddr;
  logic [reg_w-1:0]    ex_wdata, mem_wdata, wb_wdata;
  logic [aluop_w-1:0]  ex_aluop;
  logic [aluop_w-1:0]  aluop;
  logic [alusel_w-1:0] alusel;
  logic [reg_w-1:0]    reg1_data, reg2_data, link_addr;
  logic [addr_w-1:0]   waddr;
  logic                we, inst_valid, branch_flag, stallreq;
  logic [pc_w-1:0]     branch_target;

  tb_clk_gen #(.period(10), .rst_cycles(rst_cycles)) u_clk (.clk_o(clk), .rst_o(rst_gen));

  id_stage #(.nregs(32)) id_stage_i (
    .clk(clk), .rst_i(rst_gen | rst_vec), .pc_i(pc), .inst_i(inst),
    .ex_we_i(ex_we), .ex_waddr_i(ex_waddr), .ex_wdata_i(ex_wdata), .ex_aluop_i(ex_aluop),
    .mem_we_i(mem_we), .mem_waddr_i(mem_waddr), .mem_wdata_i(mem_wdata),
    .wb_we_i(wb_we), .wb_waddr_i(wb_waddr), .wb_wdata_i(wb_wdata),
    .aluop_o(aluop), .alusel_o(alusel), .reg1_data_o(reg1_data), .reg2_data_o(reg2_data),
    .waddr_o(waddr), .we_o(we), .inst_valid_o(inst_valid), .branch_flag_o(branch_flag),
    .branch_target_o(branch_target), .link_addr_o(link_addr), .stallreq_o(stallreq)
  );

  function automatic logic [31:0] field(input int v, input int f);
    return vec_mem[v*n_fld+f];
  endfunction

  task automatic check_field(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAIL %s: got %h expected %h", name, got, exp);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  task automatic apply_vector(input int v);
    rst_vec   = field(v, 0);
    pc        = field(v, 1);
    inst      = field(v, 2);
    ex_we     = field(v, 3);
    ex_waddr  = field(v, 4);
    ex_wdata  = field(v, 5);
    ex_aluop  = field(v, 6);
    mem_we    = field(v, 7);
    mem_waddr = field(v, 8);
    mem_wdata = field(v, 9);
    wb_we     = field(v, 10);
    wb_waddr  = field(v, 11);
    wb_wdata  = field(v, 12);
  endtask

  task automatic check_vector(input int v);
    check_field("aluop_o", 32'(aluop), field(v, 13));
    check_field("alusel_o", 32'(alusel), field(v, 14));
    check_field("reg1_data_o", reg1_data, field(v, 15));
    check_field("reg2_data_o", reg2_data, field(v, 16));
    check_field("waddr_o", 32'(waddr), field(v, 17));
    check_field("we_o", 32'(we), field(v, 18));
    check_field("inst_valid_o", 32'(inst_valid), field(v, 19));
    check_field("branch_flag_o", 32'(branch_flag), field(v, 20));
    check_field("branch_target_o", branch_target, field(v, 21));
    check_field("link_addr_o", link_addr, field(v, 22));
    check_field("stallreq_o", 32'(stallreq), field(v, 23));
  endtask

  task automatic check_assertions();
    check_field("u_props.fail_count", 32'(id_stage_i.u_props.fail_count), 32'd0);
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > max_cycles) begin
      $display("timeout: run went past %0d cycles", max_cycles);
      $display("Test failed");
      $fatal(1);
    end
  end

  initial begin
    cycles  = 0;
    rst_vec = 1'b0;
    pc = '0;
    inst = '0;
    ex_we = 1'b0;
    ex_waddr = '0;
    ex_wdata = '0;
    ex_aluop = '0;
    mem_we = 1'b0;
    mem_waddr = '0;
    mem_wdata = '0;
    wb_we = 1'b0;
    wb_waddr = '0;
    wb_wdata = '0;
    $readmemh("tb/id_vectors.txt", vec_mem);
    if ($isunknown(vec_mem[n_vec*n_fld-1])) begin
      $display("vector file is missing or shorter than expected");
      $display("Test failed");
      $fatal(1);
    end
    repeat (rst_cycles) @(posedge clk);
    for (int v = 0; v < n_vec; v++) begin
      @(negedge clk);
      apply_vector(v);
      #4;  // just ahead of the next rising edge
      check_vector(v);
      check_assertions();
    end
    @(negedge clk);  // last vector's properties sampled
    check_assertions();
    $display("Test completed successfully");
    $finish;
  end

endmodule
